/* switch_config.svh */
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// port count
`define NUM_PORTS 4

// frame limits in bytes
`define MIN_FRAME_LEN 14
`define MAX_FRAME_LEN 64

// queue sizes
`define DATA_FIFO_DEPTH 128 // bytes, power of two
`define LEN_FIFO_DEPTH 4 // frames, power of two

// mac table index width, 32 entries
`define TABLE_AW 5

`endif

/* switch_pkg.sv */
`include "switch_config.svh"

package switch_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;
	typedef logic [`NUM_PORTS-1:0] port_map_t; // one bit per port
	typedef logic [$clog2(`MAX_FRAME_LEN+1)-1:0] frame_len_t;
	typedef logic [`TABLE_AW-1:0] table_idx_t;

	// frame_ctrl states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER, // reading dmac and smac
		ST_LOOKUP,
		ST_COPY
	} ctrl_state_t;

endpackage

/* frame_fifo.sv */
`timescale 1ns/1ps

module frame_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = 16,
	localparam int AW = $clog2(DEPTH)
) (
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  item_t din,
	input  logic mark,
	input  logic rollback,
	input  logic rd,
	output item_t dout,
	output logic [AW:0] count,
	output logic empty,
	output logic full
);
	item_t mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] cm_ptr; // end of committed data
	logic do_wr;
	logic do_rd;

	assign count = wr_ptr - rd_ptr;
	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (cm_ptr == rd_ptr); // only committed items are readable
	assign do_wr = wr && !full && !rollback;
	assign do_rd = rd && !empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cm_ptr <= '0;
		end else begin
			if (rollback)
				wr_ptr <= cm_ptr; // forget the partial frame
			else if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (mark)
				cm_ptr <= do_wr ? wr_ptr + 1'b1 : wr_ptr;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= din;
		if (do_rd)
			dout <= mem[rd_ptr[AW-1:0]];
	end

	assert property (@(posedge clk) disable iff (rst) wr |-> !full)
		else $error("frame_fifo: write while full at %0t", $time);
	assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
		else $error("frame_fifo: read while empty at %0t", $time);

endmodule

/* rx_port.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module rx_port import switch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic rx_en,
	input  logic rx_eof,
	input  byte_t rx_data,
	input  logic len_rd,
	input  logic byte_rd,
	output logic len_valid,
	output frame_len_t len_out,
	output byte_t byte_out
);
	logic in_frame;
	logic keep; // current frame still being stored
	frame_len_t byte_cnt;
	logic [$clog2(`DATA_FIFO_DEPTH):0] data_count;
	logic len_full;
	logic len_empty;
	logic room;
	logic keep_now;
	frame_len_t cnt_next;
	logic good_eof;

	// a full-size frame must fit before its first byte is taken
	assign room = ((`DATA_FIFO_DEPTH - int'(data_count)) >= `MAX_FRAME_LEN) && !len_full;
	assign keep_now = in_frame ? (keep && byte_cnt < frame_len_t'(`MAX_FRAME_LEN)) : room;
	assign cnt_next = in_frame ? byte_cnt + 1'b1 : frame_len_t'(1);
	assign good_eof = rx_en && rx_eof && keep_now &&
		(cnt_next >= frame_len_t'(`MIN_FRAME_LEN));
	assign len_valid = !len_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_frame <= 1'b0;
			keep <= 1'b0;
			byte_cnt <= '0;
		end else if (rx_en) begin
			in_frame <= !rx_eof;
			keep <= keep_now;
			byte_cnt <= cnt_next;
		end
	end

	frame_fifo #(.item_t(byte_t), .DEPTH(`DATA_FIFO_DEPTH)) data_q (
		.clk(clk),
		.rst(rst),
		.wr(rx_en && keep_now),
		.din(rx_data),
		.mark(good_eof),
		.rollback(rx_en && rx_eof && !good_eof), // short, long or no room
		.rd(byte_rd),
		.dout(byte_out),
		.count(data_count),
		.empty(),
		.full()
	);

	frame_fifo #(.item_t(frame_len_t), .DEPTH(`LEN_FIFO_DEPTH)) len_q (
		.clk(clk),
		.rst(rst),
		.wr(good_eof),
		.din(cnt_next),
		.mark(1'b1),
		.rollback(1'b0),
		.rd(len_rd),
		.dout(len_out),
		.count(),
		.empty(len_empty),
		.full(len_full)
	);

endmodule

/* mac_table.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module mac_table import switch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic lookup_req,
	input  mac_addr_t dmac,
	input  mac_addr_t smac,
	input  port_id_t src_port,
	output logic lookup_done,
	output port_map_t dest_map
);
	localparam int ENTRIES = 1 << `TABLE_AW;
	localparam int SLICES = (48 + `TABLE_AW - 1) / `TABLE_AW;

	logic [ENTRIES-1:0] ent_valid;
	mac_addr_t ent_mac [ENTRIES];
	port_id_t ent_port [ENTRIES];

	logic s1_valid;
	mac_addr_t s1_dmac;
	mac_addr_t s1_smac;
	port_id_t s1_src;
	table_idx_t s1_s_idx;
	logic s1_d_valid;
	mac_addr_t s1_d_mac;
	port_id_t s1_d_port;
	table_idx_t d_idx;
	logic hit;
	port_map_t src_bit;
	port_map_t fwd;

	// xor of TABLE_AW-bit slices from bit 0, top slice zero padded
	function automatic table_idx_t mac_hash(input mac_addr_t mac);
		logic [SLICES*`TABLE_AW-1:0] padded;
		table_idx_t h;
		padded = (SLICES*`TABLE_AW)'(mac);
		h = '0;
		for (int i = 0; i < SLICES; i++)
			h ^= padded[i*`TABLE_AW +: `TABLE_AW];
		return h;
	endfunction

	assign d_idx = mac_hash(dmac);

	// stage 1: hash and read
	always_ff @(posedge clk) begin
		if (lookup_req) begin
			s1_dmac <= dmac;
			s1_smac <= smac;
			s1_src <= src_port;
			s1_s_idx <= mac_hash(smac);
			s1_d_valid <= ent_valid[d_idx];
			s1_d_mac <= ent_mac[d_idx];
			s1_d_port <= ent_port[d_idx];
		end
	end

	assign hit = s1_d_valid && (s1_d_mac == s1_dmac);
	assign src_bit = port_map_t'(1) << s1_src;

	always_comb begin
		if (&s1_dmac || !hit)
			fwd = ~src_bit; // flood
		else if (s1_d_port == s1_src)
			fwd = '0; // same segment, filter
		else
			fwd = port_map_t'(1) << s1_d_port;
	end

	// stage 2: result and learning
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			lookup_done <= 1'b0;
			ent_valid <= '0;
		end else begin
			s1_valid <= lookup_req;
			lookup_done <= s1_valid;
			if (s1_valid)
				ent_valid[s1_s_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			dest_map <= fwd;
			ent_mac[s1_s_idx] <= s1_smac;
			ent_port[s1_s_idx] <= s1_src;
		end
	end

	assert property (@(posedge clk) disable iff (rst) lookup_req |-> ##2 lookup_done)
		else $error("mac_table: lookup_done missing at %0t", $time);

endmodule

/* frame_ctrl.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module frame_ctrl import switch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  port_map_t len_valid,
	input  frame_len_t [`NUM_PORTS-1:0] len_out,
	input  byte_t [`NUM_PORTS-1:0] byte_out,
	input  logic lookup_done,
	input  port_map_t dest_map,
	input  port_map_t has_room,
	output port_map_t len_rd,
	output port_map_t byte_rd,
	output logic lookup_req,
	output mac_addr_t dmac,
	output mac_addr_t smac,
	output port_id_t src_port,
	output port_map_t wr_en,
	output byte_t wr_data,
	output logic wr_last
);
	localparam int HDR_LEN = 12;

	ctrl_state_t state;
	port_id_t rr_ptr; // last granted port, source of the current frame
	port_id_t grant;
	logic grant_ok;
	logic [HDR_LEN*8-1:0] hdr;
	frame_len_t cnt;
	frame_len_t flen;
	port_map_t fwd_map;
	logic rd_now;
	byte_t cur_byte;

	assign dmac = hdr[95:48];
	assign smac = hdr[47:0];
	assign src_port = rr_ptr;
	assign cur_byte = byte_out[rr_ptr];

	// round robin, search starts after the last served port
	always_comb begin
		grant = rr_ptr;
		grant_ok = 1'b0;
		for (int i = 1; i <= `NUM_PORTS; i++) begin
			if (!grant_ok && len_valid[port_id_t'(int'(rr_ptr) + i)]) begin
				grant = port_id_t'(int'(rr_ptr) + i);
				grant_ok = 1'b1;
			end
		end
	end

	// bytes show up one cycle after the read, so copy reads run one ahead
	always_comb begin
		case (state)
			ST_HEADER: rd_now = (cnt < frame_len_t'(HDR_LEN));
			ST_COPY: rd_now = (cnt >= frame_len_t'(HDR_LEN - 1)) && (cnt < flen - 1'b1);
			default: rd_now = 1'b0;
		endcase
	end

	assign len_rd = (state == ST_IDLE && grant_ok) ? (port_map_t'(1) << grant) : '0;
	assign byte_rd = rd_now ? (port_map_t'(1) << rr_ptr) : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			rr_ptr <= port_id_t'(`NUM_PORTS - 1);
			cnt <= '0;
			lookup_req <= 1'b0;
			wr_en <= '0;
			wr_last <= 1'b0;
		end else begin
			lookup_req <= 1'b0;
			wr_en <= '0;
			wr_last <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (grant_ok) begin
						rr_ptr <= grant;
						cnt <= '0;
						state <= ST_HEADER;
					end
				end
				ST_HEADER: begin
					if (cnt == '0)
						flen <= len_out[rr_ptr]; // popped in idle
					else
						hdr <= {hdr[HDR_LEN*8-9:0], cur_byte};
					cnt <= cnt + 1'b1;
					if (cnt == frame_len_t'(HDR_LEN)) begin
						lookup_req <= 1'b1;
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (lookup_done) begin
						fwd_map <= dest_map & has_room;
						cnt <= '0;
						state <= ST_COPY;
					end
				end
				ST_COPY: begin
					wr_en <= fwd_map;
					if (cnt < frame_len_t'(HDR_LEN))
						wr_data <= hdr[(HDR_LEN - 1 - int'(cnt)) * 8 +: 8];
					else
						wr_data <= cur_byte;
					wr_last <= (cnt == flen - 1'b1);
					cnt <= cnt + 1'b1;
					if (cnt == flen - 1'b1)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) $onehot0(len_rd))
		else $error("frame_ctrl: more than one length pop at %0t", $time);

endmodule

/* tx_port.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module tx_port import switch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  byte_t wr_data,
	input  logic wr_last,
	output logic has_room,
	output logic tx_en,
	output logic tx_eof,
	output byte_t tx_data
);
	logic [$clog2(`DATA_FIFO_DEPTH):0] data_count;
	logic len_full;
	logic len_empty;
	frame_len_t wr_cnt;
	frame_len_t len_head;
	frame_len_t rd_left;
	logic busy;
	logic load; // length word valid this cycle
	logic start;
	logic d_rd;
	logic last_rd;

	assign has_room = ((`DATA_FIFO_DEPTH - int'(data_count)) >= `MAX_FRAME_LEN) && !len_full;

	// first byte goes out before the length arrives, frames are never that short
	assign start = !busy && !len_empty;
	assign d_rd = start || load || (rd_left != '0);
	assign last_rd = !load && (rd_left == frame_len_t'(1));

	always_ff @(posedge clk) begin
		if (rst)
			wr_cnt <= '0;
		else if (wr_en)
			wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			load <= 1'b0;
			rd_left <= '0;
			tx_en <= 1'b0;
			tx_eof <= 1'b0;
		end else begin
			load <= start;
			tx_en <= d_rd; // lines up with the fifo output register
			tx_eof <= last_rd;
			if (start)
				busy <= 1'b1;
			else if (last_rd)
				busy <= 1'b0;
			if (load)
				rd_left <= len_head - 2'd2;
			else if (rd_left != '0)
				rd_left <= rd_left - 1'b1;
		end
	end

	frame_fifo #(.item_t(byte_t), .DEPTH(`DATA_FIFO_DEPTH)) data_q (
		.clk(clk),
		.rst(rst),
		.wr(wr_en),
		.din(wr_data),
		.mark(1'b1),
		.rollback(1'b0),
		.rd(d_rd),
		.dout(tx_data),
		.count(data_count),
		.empty(),
		.full()
	);

	frame_fifo #(.item_t(frame_len_t), .DEPTH(`LEN_FIFO_DEPTH)) len_q (
		.clk(clk),
		.rst(rst),
		.wr(wr_en && wr_last),
		.din(wr_cnt + 1'b1),
		.mark(1'b1),
		.rollback(1'b0),
		.rd(start),
		.dout(len_head),
		.count(),
		.empty(len_empty),
		.full(len_full)
	);

endmodule

/* eth_switch.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module eth_switch import switch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  port_map_t rx_en,
	input  port_map_t rx_eof,
	input  byte_t [`NUM_PORTS-1:0] rx_data,
	output port_map_t tx_en,
	output port_map_t tx_eof,
	output byte_t [`NUM_PORTS-1:0] tx_data
);
	port_map_t len_valid;
	port_map_t len_rd;
	port_map_t byte_rd;
	frame_len_t [`NUM_PORTS-1:0] len_out;
	byte_t [`NUM_PORTS-1:0] byte_out;

	logic lookup_req;
	logic lookup_done;
	mac_addr_t dmac;
	mac_addr_t smac;
	port_id_t src_port;
	port_map_t dest_map;

	port_map_t wr_en;
	byte_t wr_data;
	logic wr_last;
	port_map_t has_room;

	for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_rx
		rx_port rx_i (
			.clk(clk),
			.rst(rst),
			.rx_en(rx_en[p]),
			.rx_eof(rx_eof[p]),
			.rx_data(rx_data[p]),
			.len_rd(len_rd[p]),
			.byte_rd(byte_rd[p]),
			.len_valid(len_valid[p]),
			.len_out(len_out[p]),
			.byte_out(byte_out[p])
		);
	end

	frame_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.len_valid(len_valid),
		.len_out(len_out),
		.byte_out(byte_out),
		.lookup_done(lookup_done),
		.dest_map(dest_map),
		.has_room(has_room),
		.len_rd(len_rd),
		.byte_rd(byte_rd),
		.lookup_req(lookup_req),
		.dmac(dmac),
		.smac(smac),
		.src_port(src_port),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_last(wr_last)
	);

	mac_table table_i (
		.clk(clk),
		.rst(rst),
		.lookup_req(lookup_req),
		.dmac(dmac),
		.smac(smac),
		.src_port(src_port),
		.lookup_done(lookup_done),
		.dest_map(dest_map)
	);

	// wr_data and wr_last are shared, wr_en picks the ports
	for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_tx
		tx_port tx_i (
			.clk(clk),
			.rst(rst),
			.wr_en(wr_en[p]),
			.wr_data(wr_data),
			.wr_last(wr_last),
			.has_room(has_room[p]),
			.tx_en(tx_en[p]),
			.tx_eof(tx_eof[p]),
			.tx_data(tx_data[p])
		);
	end

endmodule

/* tb_switch.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module tb_switch import switch_pkg::*; ();
	localparam int ENTRIES = 1 << `TABLE_AW;

	logic clk;
	logic rst;
	port_map_t rx_en;
	port_map_t rx_eof;
	byte_t [`NUM_PORTS-1:0] rx_data;
	port_map_t tx_en;
	port_map_t tx_eof;
	byte_t [`NUM_PORTS-1:0] tx_data;

	logic [31:0] lfsr;
	byte_t fbuf [`NUM_PORTS][`MAX_FRAME_LEN];
	int flen [`NUM_PORTS];
	logic [8:0] exp_q [`NUM_PORTS][$]; // {eof, byte} per egress port
	logic [8:0] exp_head [`NUM_PORTS];
	port_map_t exp_avail;
	logic tbl_valid [ENTRIES];
	mac_addr_t tbl_mac [ENTRIES];
	int tbl_port [ENTRIES];
	logic [ENTRIES-1:0] used_idx; // hash slots already taken by test addresses
	mac_addr_t st_mac [`NUM_PORTS];
	int last_src;
	int errors;
	int test_errors;
	int tests;
	int failed_tests;

	eth_switch dut0 (
		.clk(clk),
		.rst(rst),
		.rx_en(rx_en),
		.rx_eof(rx_eof),
		.rx_data(rx_data),
		.tx_en(tx_en),
		.tx_eof(tx_eof),
		.tx_data(tx_data)
	);

	always #20 clk = ~clk;

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic table_idx_t hash_addr(input mac_addr_t a);
		table_idx_t h;
		h = '0;
		for (int i = 0; i < 48; i++)
			h[i % `TABLE_AW] ^= a[i];
		return h;
	endfunction

	// unicast address in a hash slot no other test address uses
	function automatic mac_addr_t pick_mac();
		mac_addr_t m;
		logic [31:0] t;
		m = '0;
		for (int k = 0; k < 64; k++) begin
			t = rand_bits(32);
			m[47:16] = t;
			t = rand_bits(16);
			m[15:0] = t[15:0];
			m[40] = 1'b0;
			if (!used_idx[hash_addr(m)])
				break;
		end
		used_idx[hash_addr(m)] = 1'b1;
		return m;
	endfunction

	function automatic int rand_len();
		return `MIN_FRAME_LEN + int'(rand_bits(6)) % (`MAX_FRAME_LEN - `MIN_FRAME_LEN + 1);
	endfunction

	function automatic void refresh_expect();
		for (int p = 0; p < `NUM_PORTS; p++) begin
			exp_avail[p] = (exp_q[p].size() > 0);
			exp_head[p] = exp_avail[p] ? exp_q[p][0] : 9'h0;
		end
	endfunction

	function automatic logic queues_empty();
		logic e;
		e = 1'b1;
		for (int p = 0; p < `NUM_PORTS; p++)
			if (exp_q[p].size() != 0)
				e = 1'b0;
		return e;
	endfunction

	task automatic build_frame(input int p, input mac_addr_t dst, input mac_addr_t src,
			input int len);
		logic [31:0] t;
		for (int i = 0; i < len; i++) begin
			if (i < 6)
				fbuf[p][i] = dst[47 - 8*i -: 8];
			else if (i < 12)
				fbuf[p][i] = src[47 - 8*(i - 6) -: 8];
			else begin
				t = rand_bits(8);
				fbuf[p][i] = t[7:0];
			end
		end
		flen[p] = len;
	endtask

	// reference: lookup, forward, then learn the source
	task automatic model_frame(input int p);
		mac_addr_t dst;
		mac_addr_t src;
		table_idx_t di;
		table_idx_t si;
		port_map_t map;
		dst = '0;
		src = '0;
		for (int i = 0; i < 6; i++) begin
			dst = {dst[39:0], fbuf[p][i]};
			src = {src[39:0], fbuf[p][i + 6]};
		end
		di = hash_addr(dst);
		map = '0;
		if (dst == '1 || !(tbl_valid[di] && tbl_mac[di] == dst)) begin
			for (int q = 0; q < `NUM_PORTS; q++)
				if (q != p)
					map[q] = 1'b1;
		end else if (tbl_port[di] != p)
			map[tbl_port[di]] = 1'b1;
		for (int q = 0; q < `NUM_PORTS; q++)
			if (map[q])
				for (int i = 0; i < flen[p]; i++)
					exp_q[q].push_back({(i == flen[p] - 1), fbuf[p][i]});
		si = hash_addr(src);
		tbl_valid[si] = 1'b1;
		tbl_mac[si] = src;
		tbl_port[si] = p;
		last_src = p;
		refresh_expect();
	endtask

	// ports in the map send in lockstep, with random idle cycles
	task automatic send_frames(input port_map_t which);
		int maxlen;
		int i;
		logic [31:0] g;
		maxlen = 0;
		for (int p = 0; p < `NUM_PORTS; p++)
			if (which[p] && flen[p] > maxlen)
				maxlen = flen[p];
		i = 0;
		while (i < maxlen) begin
			@(negedge clk);
			g = rand_bits(2);
			if (g[1:0] == 2'b00) begin
				rx_en = '0;
				rx_eof = '0;
			end else begin
				for (int p = 0; p < `NUM_PORTS; p++) begin
					rx_en[p] = which[p] && (i < flen[p]);
					rx_eof[p] = which[p] && (i == flen[p] - 1);
					rx_data[p] = fbuf[p][i];
				end
				i++;
			end
		end
		@(negedge clk);
		rx_en = '0;
		rx_eof = '0;
	endtask

	task automatic one_frame(input int p, input mac_addr_t dst, input mac_addr_t src,
			input int len);
		build_frame(p, dst, src, len);
		model_frame(p);
		send_frames(port_map_t'(1) << p);
	endtask

	task automatic wait_idle(input string what);
		int n;
		int quiet;
		logic idle;
		n = 0;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge clk);
			idle = queues_empty() && dut0.len_valid == '0 && dut0.ctrl_i.state == ST_IDLE
				&& tx_en == '0;
			// egress can start up to 2 cycles after the controller goes idle
			quiet = idle ? quiet + 1 : 0;
			n++;
			if (quiet < 4 && n > 2000) begin
				$display("timeout: switch never went idle during %s, controller in %s",
					what, dut0.ctrl_i.state.name());
				$display("Finished with errors");
				$finish;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_errors)
			$display("test %0d %s: ok", tests, name);
		else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// expected queue pops after the byte was checked on the falling edge
	always @(posedge clk) begin
		if (!rst) begin
			for (int p = 0; p < `NUM_PORTS; p++)
				if (tx_en[p] && exp_q[p].size() > 0)
					void'(exp_q[p].pop_front());
			refresh_expect();
		end
	end

	for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_chk
		assert property (@(negedge clk) disable iff (rst)
			tx_en[p] |-> exp_avail[p] && tx_data[p] == exp_head[p][7:0]
				&& tx_eof[p] == exp_head[p][8])
		else begin
			errors++;
			$display("CHECK FAILED at %0t: port %0d sent %h eof %b, expected %h eof %b%s",
				$time, p, tx_data[p], tx_eof[p], exp_head[p][7:0], exp_head[p][8],
				exp_avail[p] ? "" : " (nothing expected)");
		end
		assert property (@(negedge clk) disable iff (rst) tx_eof[p] |-> tx_en[p])
		else begin
			errors++;
			$display("CHECK FAILED at %0t: port %0d tx_eof without tx_en", $time, p);
		end
	end

	initial begin : main
		int len;
		int first;
		mac_addr_t y;
		clk = 1'b0;
		rst = 1'b1;
		rx_en = '0;
		rx_eof = '0;
		rx_data = '0;
		lfsr = 32'h3f9b;
		errors = 0;
		test_errors = 0;
		tests = 0;
		failed_tests = 0;
		last_src = `NUM_PORTS - 1;
		for (int i = 0; i < ENTRIES; i++)
			tbl_valid[i] = 1'b0;
		refresh_expect();
		used_idx = '0;
		used_idx[hash_addr('1)] = 1'b1;
		for (int p = 0; p < `NUM_PORTS; p++)
			st_mac[p] = pick_mac();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		y = pick_mac();
		len = rand_len();
		one_frame(0, y, st_mac[0], len);
		wait_idle("unknown unicast");
		end_test("unknown unicast flood");

		len = rand_len();
		one_frame(1, st_mac[0], st_mac[1], len);
		wait_idle("learned unicast");
		end_test("learned unicast");

		len = rand_len();
		one_frame(3, st_mac[2], '1, len); // teaches the broadcast address on port 3
		wait_idle("broadcast source");
		len = rand_len();
		one_frame(2, '1, st_mac[2], len);
		wait_idle("broadcast");
		end_test("broadcast flood");

		y = pick_mac();
		len = rand_len();
		one_frame(0, st_mac[0], y, len);
		wait_idle("same port filter");
		end_test("same port filter");

		y = pick_mac();
		len = `MIN_FRAME_LEN - 2 + int'(rand_bits(1)); // whole header, source included
		build_frame(3, st_mac[0], y, len);
		send_frames(4'b1000); // too short, no model entry
		wait_idle("short frame");
		len = rand_len();
		one_frame(1, y, st_mac[1], len);
		wait_idle("frame to unlearned source");
		end_test("short frame dropped");

		len = rand_len();
		for (int p = 0; p < `NUM_PORTS; p++)
			build_frame(p, st_mac[(p + 1) % `NUM_PORTS], st_mac[p], len);
		first = last_src;
		for (int i = 1; i <= `NUM_PORTS; i++)
			model_frame((first + i) % `NUM_PORTS); // round robin service order
		send_frames('1);
		wait_idle("four port burst");
		end_test("four port burst");

		for (int p = 0; p < `NUM_PORTS; p++)
			assert (exp_q[p].size() == 0)
			else begin
				errors++;
				$display("port %0d still expects %0d bytes at the end", p, exp_q[p].size());
			end

		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
switch_pkg.sv
frame_fifo.sv
rx_port.sv
mac_table.sv
frame_ctrl.sv
tx_port.sv
eth_switch.sv
tb_switch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tb_switch
FILELIST = list.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
